/* sim/cpuStim.mem */
// program word count, then the program words placed from the reset pc,
// then the store count, then one store per line as address and data
00000025
00500093 // addi x1, x0, 5
00700113 // addi x2, x0, 7
002081B3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
00402023 // sw   x4, 0(x0)
123452B7 // lui  x5, 0x12345
0032C333 // xor  x6, x5, x3
00602223 // sw   x6, 4(x0)
00402383 // lw   x7, 4(x0)
00138413 // addi x8, x7, 1
00802423 // sw   x8, 8(x0)
00208463 // beq  x1, x2, +8
00102623 // sw   x1, 12(x0)
00209463 // bne  x1, x2, +8
00202623 // sw   x2, 12(x0) skipped
008004EF // jal  x9, +8
00202823 // sw   x2, 16(x0) skipped
00902823 // sw   x9, 16(x0)
FFD00513 // addi x10, x0, -3
001525B3 // slt  x11, x10, x1
00153633 // sltu x12, x10, x1
40B556B3 // sra  x13, x10, x11
00409713 // slli x14, x1, 4
00B767B3 // or   x15, x14, x11
0047F833 // and  x16, x15, x4
00B2D8B3 // srl  x17, x5, x11
01002E23 // sw   x16, 28(x0)
03102023 // sw   x17, 32(x0)
00D02A23 // sw   x13, 20(x0)
00F02C23 // sw   x15, 24(x0)
00154463 // blt  x10, x1, +8
02002223 // sw   x0, 36(x0) skipped
00155463 // bge  x10, x1, +8
02C02223 // sw   x12, 36(x0)
02B02423 // sw   x11, 40(x0)
00000073 // ecall
02102623 // sw   x1, 44(x0) never reached
0000000B
00000000 00000007
00000004 1234500C
00000008 1234500D
0000000C 00000005
00000010 00000040
0000001C 00000001
00000020 091A2800
00000014 FFFFFFFE
00000018 00000051
00000024 00000000
00000028 00000001

/* project.f */
hdl/rvPkg.sv
hdl/pcUnit.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/cpuTop.sv
sim/cpuTb.sv

/* Bender.yml */
package:
  name: rvPipe

sources:
  - hdl/rvPkg.sv
  - hdl/pcUnit.sv
  - hdl/decoder.sv
  - hdl/regFile.sv
  - hdl/hazardUnit.sv
  - hdl/executeUnit.sv
  - hdl/cpuTop.sv
  - target: simulation
    files:
      - sim/cpuTb.sv

/* sim/cpuTb.sv */
`default_nettype none

module cpuTb;

  import rvPkg::*;

  localparam word_t resetPc    = 32'h0000_0000;
  localparam int    stimDepth  = 256;
  localparam int    tailCycles = 16;

  logic  clk;
  logic  rst;
  word_t imemAddr;
  word_t imemData;
  word_t dmemAddr;
  word_t dmemWdata;
  logic  dmemWe;
  word_t dmemRdata;
  logic  ecall;

  word_t stimWords [0:stimDepth-1];
  word_t imem [0:255];
  word_t dmem [0:255];
  word_t expAddr [0:63];
  word_t expData [0:63];

  int    progLen;
  int    storeCount;
  int    storeIdx;
  int    cycles;
  int    timeoutLimit;
  int    errors;
  int    checks;
  logic  haltSeen;
  word_t frozenPc;

  cpuTop #(.resetPc(resetPc)) dut (
    .clk         (clk),
    .rst         (rst),
    .imemAddr_o  (imemAddr),
    .imemData_i  (imemData),
    .dmemAddr_o  (dmemAddr),
    .dmemWdata_o (dmemWdata),
    .dmemWe_o    (dmemWe),
    .dmemRdata_i (dmemRdata),
    .ecall_o     (ecall)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ==============================
  // helpers
  // ==============================
  task automatic checkWord(input string name, input word_t expected, input word_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic loadStimulus();
    int base;
    $readmemh("sim/cpuStim.mem", stimWords);
    // unused slots hold addi x0, x0, index so every word differs
    for (int i = 0; i < 256; i++) begin
      imem[i] = (word_t'(i) << 20) | 32'h0000_0013;
      dmem[i] = '0;
    end
    assert (!$isunknown(stimWords[0])) else begin
      errors++;
      $display("stimulus file could not be read");
    end
    progLen = $isunknown(stimWords[0]) ? 0 : int'(stimWords[0]);
    for (int i = 0; i < progLen; i++) begin
      imem[resetPc[9:2] + i] = stimWords[1 + i];
    end
    storeCount = int'(stimWords[1 + progLen]);
    base = 2 + progLen;
    for (int k = 0; k < storeCount; k++) begin
      expAddr[k] = stimWords[base + 2 * k];
      expData[k] = stimWords[base + 2 * k + 1];
    end
    timeoutLimit = 8 * progLen + 60;
  endtask

  task automatic handleStore();
    assert (!haltSeen) else begin
      errors++;
      $display("store to %h issued after ecall_o rose", dmemAddr);
    end
    assert (storeIdx < storeCount) else begin
      errors++;
      $display("unexpected store to %h with data %h beyond the %0d expected",
               dmemAddr, dmemWdata, storeCount);
    end
    if (storeIdx < storeCount) begin
      checkWord("dmemAddr_o", expAddr[storeIdx], dmemAddr);
      checkWord("dmemWdata_o", expData[storeIdx], dmemWdata);
    end
    storeIdx++;
    assert (dmemAddr < 32'd1024 && dmemAddr[1:0] == 2'b00) else begin
      errors++;
      $display("store address %h lies outside the data memory", dmemAddr);
    end
    if (dmemAddr < 32'd1024) begin
      dmem[dmemAddr[9:2]] = dmemWdata;
    end
  endtask

  // both memories answer from the address the DUT holds this cycle
  task automatic driveMemories();
    imemData  = imem[imemAddr[9:2]];
    dmemRdata = dmem[dmemAddr[9:2]];
  endtask

  task automatic stepCycle();
    @(negedge clk);
    cycles++;
    if (dmemWe === 1'b1) begin
      handleStore();
    end
    driveMemories();
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    rst       = 1'b1;
    imemData  = NOP_INSTR;
    dmemRdata = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    storeIdx  = 0;
    haltSeen  = 1'b0;
    frozenPc  = '0;
    loadStimulus();

    repeat (8) begin
      stepCycle();
      checkWord("imemAddr_o", resetPc, imemAddr);
      checkWord("dmemWe_o", 32'd0, word_t'(dmemWe));
      checkWord("ecall_o", 32'd0, word_t'(ecall));
    end
    rst = 1'b0;

    // stores are checked inside stepCycle as they appear
    while (ecall !== 1'b1 && cycles < timeoutLimit) begin
      stepCycle();
    end

    if (ecall !== 1'b1) begin
      errors++;
      $display("timeout: ecall_o did not rise within %0d cycles", timeoutLimit);
    end else begin
      assert (storeIdx == storeCount) else begin
        errors++;
        $display("ecall_o rose after only %0d of %0d expected stores", storeIdx, storeCount);
      end
      haltSeen = 1'b1;
      frozenPc = imemAddr;
      // halted core keeps its pc and stays quiet
      repeat (tailCycles) begin
        stepCycle();
        checkWord("ecall_o", 32'd1, word_t'(ecall));
        checkWord("imemAddr_o", frozenPc, imemAddr);
      end
    end

    $display("checks %0d, errors %0d, stores %0d of %0d",
             checks, errors, storeIdx, storeCount);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
`default_nettype none

module cpuTop #(
  parameter rvPkg::word_t resetPc = 32'h0000_0000
) (
  input  wire logic         clk,
  input  wire logic         rst,
  output rvPkg::word_t      imemAddr_o,
  input  wire rvPkg::word_t imemData_i,
  output rvPkg::word_t      dmemAddr_o,
  output rvPkg::word_t      dmemWdata_o,
  output logic              dmemWe_o,
  input  wire rvPkg::word_t dmemRdata_i,
  output logic              ecall_o
);

  import rvPkg::*;

  // decode
  word_t    idPc, idImm, idRs1Data, idRs2Data;
  regAddr_t idRs1, idRs2, idRd;
  aluOp_t   idAluOp;
  brOp_t    idBrOp;
  wbSel_t   idWbSel;
  logic     idUseImm, idUseRs1, idUseRs2, idRegWe, idMemRead, idMemWrite;
  logic     idIsBranch, idIsJump, idIsEcall;

  // execute
  word_t    exPc, exRs1Data, exRs2Data, exImm;
  regAddr_t exRs1, exRs2, exRd;
  aluOp_t   exAluOp;
  brOp_t    exBrOp;
  wbSel_t   exWbSel;
  logic     exUseImm, exRegWe, exMemRead, exMemWrite, exIsBranch, exIsJump, exIsEcall;
  word_t    exAluResult, exStoreData, exTarget;
  logic     exRedirect;

  // memory
  word_t    memPc, memAlu, memStoreData, memFwdValue;
  regAddr_t memRd;
  wbSel_t   memWbSel;
  logic     memRegWe, memMemWrite, memIsEcall;

  // writeback
  word_t    wbPc, wbAlu, wbMemData, wbValue;
  regAddr_t wbRd;
  wbSel_t   wbWbSel;
  logic     wbRegWe, wbIsEcall;

  // hazards and halt
  logic     stall, flush, haltReq, haltQ, idExBubble;
  fwdSel_t  fwdA, fwdB;

  // ==============================
  // fetch and decode
  // ==============================
  pcUnit #(.resetPc(resetPc)) uPc (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall),
    .halt_i     (haltReq),
    .redirect_i (exRedirect),
    .target_i   (exTarget),
    .pc_o       (imemAddr_o)
  );

  // halt bubbles the fetch slot like a flush
  decoder uDecoder (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall),
    .flush_i    (flush || haltReq),
    .instr_i    (imemData_i),
    .pc_i       (imemAddr_o),
    .pc_o       (idPc),
    .rs1_o      (idRs1),
    .rs2_o      (idRs2),
    .rd_o       (idRd),
    .imm_o      (idImm),
    .aluOp_o    (idAluOp),
    .useImm_o   (idUseImm),
    .useRs1_o   (idUseRs1),
    .useRs2_o   (idUseRs2),
    .regWe_o    (idRegWe),
    .memRead_o  (idMemRead),
    .memWrite_o (idMemWrite),
    .isBranch_o (idIsBranch),
    .isJump_o   (idIsJump),
    .isEcall_o  (idIsEcall),
    .brOp_o     (idBrOp),
    .wbSel_o    (idWbSel)
  );

  regFile uRegFile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (idRs1),
    .raddr2_i (idRs2),
    .waddr_i  (wbRd),
    .we_i     (wbRegWe),
    .wdata_i  (wbValue),
    .rdata1_o (idRs1Data),
    .rdata2_o (idRs2Data)
  );

  hazardUnit uHazard (
    .idRs1_i     (idRs1),
    .idRs2_i     (idRs2),
    .idUseRs1_i  (idUseRs1),
    .idUseRs2_i  (idUseRs2),
    .exRs1_i     (exRs1),
    .exRs2_i     (exRs2),
    .exRd_i      (exRd),
    .exMemRead_i (exMemRead),
    .memRd_i     (memRd),
    .memRegWe_i  (memRegWe),
    .wbRd_i      (wbRd),
    .wbRegWe_i   (wbRegWe),
    .redirect_i  (exRedirect),
    .stall_o     (stall),
    .flush_o     (flush),
    .fwdA_o      (fwdA),
    .fwdB_o      (fwdB)
  );

  // ==============================
  // ID/EX
  // ==============================
  assign idExBubble = stall || flush || haltReq;

  always_ff @(posedge clk) begin
    if (rst || idExBubble) begin
      exRegWe    <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exIsBranch <= 1'b0;
      exIsJump   <= 1'b0;
      exIsEcall  <= 1'b0;
    end else begin
      exRegWe    <= idRegWe;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
      exIsBranch <= idIsBranch;
      exIsJump   <= idIsJump;
      exIsEcall  <= idIsEcall;
    end
  end

  always_ff @(posedge clk) begin
    exPc      <= idPc;
    exRs1Data <= idRs1Data;
    exRs2Data <= idRs2Data;
    exImm     <= idImm;
    exRs1     <= idRs1;
    exRs2     <= idRs2;
    exRd      <= idRd;
    exAluOp   <= idAluOp;
    exUseImm  <= idUseImm;
    exBrOp    <= idBrOp;
    exWbSel   <= idWbSel;
  end

  executeUnit uExecute (
    .pc_i        (exPc),
    .rs1Data_i   (exRs1Data),
    .rs2Data_i   (exRs2Data),
    .imm_i       (exImm),
    .aluOp_i     (exAluOp),
    .useImm_i    (exUseImm),
    .isBranch_i  (exIsBranch),
    .isJump_i    (exIsJump),
    .brOp_i      (exBrOp),
    .fwdA_i      (fwdA),
    .fwdB_i      (fwdB),
    .memAlu_i    (memFwdValue),
    .wbValue_i   (wbValue),
    .aluResult_o (exAluResult),
    .storeData_o (exStoreData),
    .target_o    (exTarget),
    .redirect_o  (exRedirect)
  );

  // ==============================
  // EX/MEM
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      memRegWe    <= 1'b0;
      memMemWrite <= 1'b0;
      memIsEcall  <= 1'b0;
    end else begin
      memRegWe    <= exRegWe;
      memMemWrite <= exMemWrite;
      memIsEcall  <= exIsEcall;
    end
  end

  always_ff @(posedge clk) begin
    memPc        <= exPc;
    memAlu       <= exAluResult;
    memStoreData <= exStoreData;
    memRd        <= exRd;
    memWbSel     <= exWbSel;
  end

  // jal in MEM forwards its link, a load its read data
  always_comb begin
    case (memWbSel)
      WB_MEM:  memFwdValue = dmemRdata_i;
      WB_PC4:  memFwdValue = memPc + 32'd4;
      default: memFwdValue = memAlu;
    endcase
  end

  assign dmemAddr_o  = memAlu;
  assign dmemWdata_o = memStoreData;
  assign dmemWe_o    = memMemWrite;

  // ==============================
  // MEM/WB and writeback
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      wbRegWe   <= 1'b0;
      wbIsEcall <= 1'b0;
    end else begin
      wbRegWe   <= memRegWe;
      wbIsEcall <= memIsEcall;
    end
  end

  always_ff @(posedge clk) begin
    wbPc      <= memPc;
    wbAlu     <= memAlu;
    wbMemData <= dmemRdata_i;
    wbRd      <= memRd;
    wbWbSel   <= memWbSel;
  end

  always_comb begin
    case (wbWbSel)
      WB_MEM:  wbValue = wbMemData;
      WB_PC4:  wbValue = wbPc + 32'd4;
      default: wbValue = wbAlu;
    endcase
  end

  // ==============================
  // halt
  // ==============================
  // once ecall is past decode everything younger is bubbled
  assign haltReq = exIsEcall || memIsEcall || wbIsEcall || haltQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      haltQ <= 1'b0;
    end else if (wbIsEcall) begin
      haltQ <= 1'b1;
    end
  end

  assign ecall_o = haltQ;

  // the halt keeps the store port quiet for good
  noStoreAfterHalt: assert property (@(posedge clk) disable iff (rst) haltQ |-> !dmemWe_o)
    else $error("store issued after ecall halt");

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
`default_nettype none

module executeUnit (
  input  wire rvPkg::word_t   pc_i,
  input  wire rvPkg::word_t   rs1Data_i,
  input  wire rvPkg::word_t   rs2Data_i,
  input  wire rvPkg::word_t   imm_i,
  input  wire rvPkg::aluOp_t  aluOp_i,
  input  wire logic           useImm_i,
  input  wire logic           isBranch_i,
  input  wire logic           isJump_i,
  input  wire rvPkg::brOp_t   brOp_i,
  input  wire rvPkg::fwdSel_t fwdA_i,
  input  wire rvPkg::fwdSel_t fwdB_i,
  input  wire rvPkg::word_t   memAlu_i,
  input  wire rvPkg::word_t   wbValue_i,
  output rvPkg::word_t        aluResult_o,
  output rvPkg::word_t        storeData_o,
  output rvPkg::word_t        target_o,
  output logic                redirect_o
);

  import rvPkg::*;

  word_t opA;
  word_t opB;
  word_t aluB;
  logic  taken;

  function automatic word_t pickOperand(input fwdSel_t sel, input word_t rfData,
                                        input word_t memData, input word_t wbData);
    case (sel)
      FWD_MEM: return memData;
      FWD_WB:  return wbData;
      default: return rfData;
    endcase
  endfunction

  // forwarded registers also feed the comparator and store data
  assign opA         = pickOperand(fwdA_i, rs1Data_i, memAlu_i, wbValue_i);
  assign opB         = pickOperand(fwdB_i, rs2Data_i, memAlu_i, wbValue_i);
  assign aluB        = useImm_i ? imm_i : opB;
  assign storeData_o = opB;

  always_comb begin
    case (aluOp_i)
      ALU_ADD:   aluResult_o = opA + aluB;
      ALU_SUB:   aluResult_o = opA - aluB;
      ALU_AND:   aluResult_o = opA & aluB;
      ALU_OR:    aluResult_o = opA | aluB;
      ALU_XOR:   aluResult_o = opA ^ aluB;
      ALU_SLT:   aluResult_o = {31'b0, $signed(opA) < $signed(aluB)};
      ALU_SLTU:  aluResult_o = {31'b0, opA < aluB};
      ALU_SLL:   aluResult_o = opA << aluB[4:0];
      ALU_SRL:   aluResult_o = opA >> aluB[4:0];
      ALU_SRA:   aluResult_o = $signed(opA) >>> aluB[4:0];
      ALU_PASSB: aluResult_o = aluB;
      default:   aluResult_o = '0;
    endcase
  end

  always_comb begin
    case (brOp_i)
      BR_EQ:   taken = (opA == opB);
      BR_NE:   taken = (opA != opB);
      BR_LT:   taken = ($signed(opA) < $signed(opB));
      default: taken = ($signed(opA) >= $signed(opB));
    endcase
  end

  // branch and jal share pc-relative target
  assign target_o   = pc_i + imm_i;
  assign redirect_o = isJump_i || (isBranch_i && taken);

  fwdLegal: assert final (fwdA_i inside {FWD_RF, FWD_MEM, FWD_WB} &&
                          fwdB_i inside {FWD_RF, FWD_MEM, FWD_WB})
    else $error("unused forward select code: A=%0d B=%0d", fwdA_i, fwdB_i);

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`default_nettype none

module hazardUnit (
  input  wire rvPkg::regAddr_t idRs1_i,
  input  wire rvPkg::regAddr_t idRs2_i,
  input  wire logic            idUseRs1_i,
  input  wire logic            idUseRs2_i,
  input  wire rvPkg::regAddr_t exRs1_i,
  input  wire rvPkg::regAddr_t exRs2_i,
  input  wire rvPkg::regAddr_t exRd_i,
  input  wire logic            exMemRead_i,
  input  wire rvPkg::regAddr_t memRd_i,
  input  wire logic            memRegWe_i,
  input  wire rvPkg::regAddr_t wbRd_i,
  input  wire logic            wbRegWe_i,
  input  wire logic            redirect_i,
  output logic                 stall_o,
  output logic                 flush_o,
  output rvPkg::fwdSel_t       fwdA_o,
  output rvPkg::fwdSel_t       fwdB_o
);

  import rvPkg::*;

  // newest producer wins
  function automatic fwdSel_t selectFwd(input logic memHit, input logic wbHit);
    if (memHit) begin
      return FWD_MEM;
    end
    if (wbHit) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign fwdA_o = selectFwd(memRegWe_i && memRd_i == exRs1_i,
                            wbRegWe_i && wbRd_i == exRs1_i);
  assign fwdB_o = selectFwd(memRegWe_i && memRd_i == exRs2_i,
                            wbRegWe_i && wbRd_i == exRs2_i);

  // load in EX feeding the instruction in decode
  assign stall_o = exMemRead_i && exRd_i != '0 &&
                   ((idUseRs1_i && idRs1_i == exRd_i) || (idUseRs2_i && idRs2_i == exRd_i));

  assign flush_o = redirect_i;

  // a redirecting branch or jal in EX is never a load
  noStallFlush: assert final (!(stall_o && flush_o))
    else $error("load-use stall and redirect flush in the same cycle");

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire rvPkg::regAddr_t raddr1_i,
  input  wire rvPkg::regAddr_t raddr2_i,
  input  wire rvPkg::regAddr_t waddr_i,
  input  wire logic            we_i,
  input  wire rvPkg::word_t    wdata_i,
  output rvPkg::word_t         rdata1_o,
  output rvPkg::word_t         rdata2_o
);

  import rvPkg::*;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through so decode sees the value retiring in WB
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (we_i && raddr1_i == waddr_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (we_i && raddr2_i == waddr_i) ? wdata_i : regs[raddr2_i];

  // decode drops x0 writes before they enter the pipe
  noWriteX0: assert property (@(posedge clk) disable iff (rst) we_i |-> waddr_i != '0)
    else $error("register write to x0 reached WB");

endmodule

`default_nettype wire

/* hdl/decoder.sv */
`default_nettype none

module decoder (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         stall_i,
  input  wire logic         flush_i,
  input  wire rvPkg::word_t instr_i,
  input  wire rvPkg::word_t pc_i,
  output rvPkg::word_t      pc_o,
  output rvPkg::regAddr_t   rs1_o,
  output rvPkg::regAddr_t   rs2_o,
  output rvPkg::regAddr_t   rd_o,
  output rvPkg::word_t      imm_o,
  output rvPkg::aluOp_t     aluOp_o,
  output logic              useImm_o,
  output logic              useRs1_o,
  output logic              useRs2_o,
  output logic              regWe_o,
  output logic              memRead_o,
  output logic              memWrite_o,
  output logic              isBranch_o,
  output logic              isJump_o,
  output logic              isEcall_o,
  output rvPkg::brOp_t      brOp_o,
  output rvPkg::wbSel_t     wbSel_o
);

  import rvPkg::*;

  word_t      instrQ;
  word_t      immI, immS, immB, immU, immJ;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       writes;

  function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ==============================
  // IF/ID register
  // ==============================
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      instrQ <= NOP_INSTR;
    end else if (!stall_i) begin
      instrQ <= instr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_o <= pc_i;
    end
  end

  assign opcode = instrQ[6:0];
  assign funct3 = instrQ[14:12];
  assign rs1_o  = instrQ[19:15];
  assign rs2_o  = instrQ[24:20];
  assign rd_o   = instrQ[11:7];

  // ==============================
  // immediates
  // ==============================
  assign immI = {{20{instrQ[31]}}, instrQ[31:20]};
  assign immS = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
  assign immB = {{19{instrQ[31]}}, instrQ[31], instrQ[7], instrQ[30:25], instrQ[11:8], 1'b0};
  assign immU = {instrQ[31:12], 12'b0};
  assign immJ = {{11{instrQ[31]}}, instrQ[31], instrQ[19:12], instrQ[20], instrQ[30:21], 1'b0};

  // ==============================
  // control decode
  // ==============================
  always_comb begin
    imm_o      = immI;
    aluOp_o    = ALU_ADD;
    useImm_o   = 1'b0;
    useRs1_o   = 1'b0;
    useRs2_o   = 1'b0;
    writes     = 1'b0;
    memRead_o  = 1'b0;
    memWrite_o = 1'b0;
    isBranch_o = 1'b0;
    isJump_o   = 1'b0;
    isEcall_o  = 1'b0;
    brOp_o     = BR_EQ;
    wbSel_o    = WB_ALU;
    case (opcode)
      OPC_OP: begin
        useRs1_o = 1'b1;
        useRs2_o = 1'b1;
        writes   = 1'b1;
        aluOp_o  = aluFromFunct(funct3, instrQ[30]);
      end
      OPC_OPIMM: begin
        // bit 30 only selects sra here, for addi it is immediate
        useRs1_o = 1'b1;
        useImm_o = 1'b1;
        writes   = 1'b1;
        aluOp_o  = aluFromFunct(funct3, instrQ[30] && funct3 == 3'b101);
      end
      OPC_LUI: begin
        useImm_o = 1'b1;
        writes   = 1'b1;
        imm_o    = immU;
        aluOp_o  = ALU_PASSB;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          useRs1_o  = 1'b1;
          useImm_o  = 1'b1;
          writes    = 1'b1;
          memRead_o = 1'b1;
          wbSel_o   = WB_MEM;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          useRs1_o   = 1'b1;
          useRs2_o   = 1'b1;
          useImm_o   = 1'b1;
          memWrite_o = 1'b1;
          imm_o      = immS;
        end
      end
      OPC_BRANCH: begin
        // beq bne blt bge, unsigned forms stay bubbles
        if (!funct3[1]) begin
          useRs1_o   = 1'b1;
          useRs2_o   = 1'b1;
          isBranch_o = 1'b1;
          imm_o      = immB;
          brOp_o     = {funct3[2], funct3[0]};
        end
      end
      OPC_JAL: begin
        writes   = 1'b1;
        isJump_o = 1'b1;
        imm_o    = immJ;
        wbSel_o  = WB_PC4;
      end
      OPC_SYSTEM: begin
        isEcall_o = (instrQ[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

  // x0 is never written
  assign regWe_o = writes && (rd_o != '0);

endmodule

`default_nettype wire

/* hdl/pcUnit.sv */
`default_nettype none

module pcUnit #(
  parameter rvPkg::word_t resetPc = 32'h0000_0000
) (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         stall_i,
  input  wire logic         halt_i,
  input  wire logic         redirect_i,
  input  wire rvPkg::word_t target_i,
  output rvPkg::word_t      pc_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= resetPc;
    end else if (redirect_i) begin
      // branch or jal resolved in EX
      pc_o <= target_i;
    end else if (!stall_i && !halt_i) begin
      pc_o <= pc_o + 32'd4;
    end
  end

  // targets come from EX immediates, so this also covers decode
  pcAligned: assert property (@(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc_o);

endmodule

`default_nettype wire

/* hdl/rvPkg.sv */
`default_nettype none

package rvPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [3:0]  aluOp_t;
  typedef logic [1:0]  brOp_t;
  typedef logic [1:0]  wbSel_t;
  typedef logic [1:0]  fwdSel_t;

  localparam int NUM_REGS = 32;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // alu operations
  localparam aluOp_t ALU_ADD   = 4'd0;
  localparam aluOp_t ALU_SUB   = 4'd1;
  localparam aluOp_t ALU_AND   = 4'd2;
  localparam aluOp_t ALU_OR    = 4'd3;
  localparam aluOp_t ALU_XOR   = 4'd4;
  localparam aluOp_t ALU_SLT   = 4'd5;
  localparam aluOp_t ALU_SLTU  = 4'd6;
  localparam aluOp_t ALU_SLL   = 4'd7;
  localparam aluOp_t ALU_SRL   = 4'd8;
  localparam aluOp_t ALU_SRA   = 4'd9;
  localparam aluOp_t ALU_PASSB = 4'd10;

  // branch conditions, encoded as {funct3[2], funct3[0]}
  localparam brOp_t BR_EQ = 2'd0;
  localparam brOp_t BR_NE = 2'd1;
  localparam brOp_t BR_LT = 2'd2;
  localparam brOp_t BR_GE = 2'd3;

  // writeback sources
  localparam wbSel_t WB_ALU = 2'd0;
  localparam wbSel_t WB_MEM = 2'd1;
  localparam wbSel_t WB_PC4 = 2'd2;

  // operand sources in EX
  localparam fwdSel_t FWD_RF  = 2'd0;
  localparam fwdSel_t FWD_MEM = 2'd1;
  localparam fwdSel_t FWD_WB  = 2'd2;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
